// File: Makefile
TOP = spi_bridge_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// File: sources.f
verilog/spi_pkg.sv
verilog/spi_layer.sv
verilog/spi_slave.sv
verilog/bus_arbiter.sv
verilog/reg_bank.sv
verilog/spi_bridge_top.sv
tests/spi_bridge_clkgen.sv
tests/spi_bridge_chk.sv
tests/spi_bridge_tb.sv

// File: tests/spi_bridge_chk.sv
`timescale 1ns/1ps

module spi_bridge_chk (
   input logic clk_i,
   input logic rst_i,
   input logic m0_cyc_i,
   input logic m0_stb_i,
   input logic m0_ack_o,
   input logic m1_cyc_i,
   input logic m1_stb_i,
   input logic m1_ack_o,
   input logic gnt
);

   // ack only for an access the master strobed while granted
   ack_m0_served : assert property (@(posedge clk_i) disable iff (rst_i)
      m0_ack_o |-> $past(!gnt && m0_stb_i))
      else $error("ack to master 0 without its granted strobe");
   ack_m1_served : assert property (@(posedge clk_i) disable iff (rst_i)
      m1_ack_o |-> $past(gnt && m1_stb_i))
      else $error("ack to master 1 without its granted strobe");

   // grant sticks while the owner keeps cyc up
   gnt_m0_kept : assert property (@(posedge clk_i) disable iff (rst_i)
      (!gnt && m0_cyc_i) |=> (!m0_cyc_i || !gnt)) else $error("grant left master 0");
   gnt_m1_kept : assert property (@(posedge clk_i) disable iff (rst_i)
      (gnt && m1_cyc_i) |=> (!m1_cyc_i || gnt)) else $error("grant left master 1");

   // stb stays up until ack in a classic cycle
   stb_m0_held : assert property (@(posedge clk_i) disable iff (rst_i)
      (m0_stb_i && !m0_ack_o) |=> m0_stb_i) else $error("master 0 dropped stb early");
   stb_m1_held : assert property (@(posedge clk_i) disable iff (rst_i)
      (m1_stb_i && !m1_ack_o) |=> m1_stb_i) else $error("master 1 dropped stb early");

endmodule

bind bus_arbiter spi_bridge_chk u_spi_bridge_chk (.*);

// File: tests/spi_bridge_clkgen.sv
`timescale 1ns/1ps

module spi_bridge_clkgen #(
   parameter real PERIOD_NS  = 40.0,
   parameter int  RST_CYCLES = 3
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   initial begin
      rst_o = 1'b1; // held over the first rising edges
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

// File: tests/spi_bridge_tb.sv
`timescale 1ns/1ps

module spi_bridge_tb;
   import spi_pkg::*;

   localparam logic [7:0] HDR     = 8'hA7;
   localparam int         HALF    = 8;       // sck half period in clocks
   localparam int         OP_NS   = 1200*40; // generous bound per operation
   localparam int         MARGIN  = 20000;

   logic        clk;
   logic        rst;
   logic        sck, ssel, mosi;
   logic [7:0]  status;
   logic        loc_cyc, loc_stb, loc_we;
   logic [6:0]  loc_adr;
   logic [7:0]  loc_dat;
   logic        loc_ack, miso, active, overflow, underrun;
   logic [7:0]  loc_rdat;

   int          errors = 0;
   int          n_ops = 0;
   int          op_q[$];
   logic [7:0]  adr_q[$], dat_q[$], exp_q[$];
   logic [7:0]  rx_q[$];       // miso bytes of the last frame
   logic [7:0]  model [128];   // expected bank contents
   logic [31:0] lfsr = 32'ha07e7d49;

   spi_bridge_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

   spi_bridge_top #(.HEADER_BYTE(HDR), .SYNC_STAGES(2)) u_spi_bridge_top (
      .clk_i(clk), .rst_i(rst),
      .sck_i(sck), .ssel_i(ssel), .mosi_i(mosi), .miso_o(miso),
      .status_i(status),
      .loc_cyc_i(loc_cyc), .loc_stb_i(loc_stb), .loc_we_i(loc_we),
      .loc_adr_i(loc_adr), .loc_dat_i(loc_dat),
      .loc_ack_o(loc_ack), .loc_dat_o(loc_rdat),
      .active_o(active), .overflow_o(overflow), .underrun_o(underrun)
   );

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic rand_bits(input int n, output logic [7:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0); // galois step
         v    = {v[6:0], lfsr[0]};
      end
   endtask

   // n data bytes follow the command and the last one is wdat
   task automatic spi_frame(input logic [7:0] cmd, input int n, input logic [7:0] wdat);
      logic [7:0] tx;
      logic [7:0] rx;
      rx_q.delete();
      ssel = 1'b0;
      repeat (HALF) @(negedge clk);
      check_val("active_o", {7'b0, active}, 8'h01);
      for (int k = 0; k <= n; k++) begin
         tx = (k == 0) ? cmd : (k == n) ? wdat : wdat ^ 8'(8'h5a + k);
         for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            repeat (HALF) @(negedge clk);
            rx[b] = miso;  // stable just before the rise
            sck   = 1'b1;
            repeat (HALF) @(negedge clk);
            sck = 1'b0;
         end
         rx_q.push_back(rx);
      end
      check_val("miso_header", rx_q[0], HDR);
      repeat (2*HALF) @(negedge clk); // let the last bus access end
      ssel = 1'b1;
      repeat (2*HALF) @(negedge clk);
      check_val("active_o", {7'b0, active}, 8'h00);
   endtask

   task automatic loc_access(input logic we, input logic [6:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdat);
      int wait_cnt;
      wait_cnt = 0;
      loc_cyc = 1'b1;
      loc_stb = 1'b1;
      loc_we  = we;
      loc_adr = adr;
      loc_dat = dat;
      do begin
         @(negedge clk);
         wait_cnt++;
      end while (!loc_ack && wait_cnt < 1000);
      assert (loc_ack) else begin
         $display("local port got no ack at t=%0t", $time);
         errors++;
      end
      rdat = loc_rdat;
      @(negedge clk); // access ends at the rising edge that samples ack
      loc_cyc = 1'b0;
      loc_stb = 1'b0;
      loc_we  = 1'b0;
   endtask

   task automatic flags_low();
      check_val("overflow_o", {7'b0, overflow}, 8'h00);
      check_val("underrun_o", {7'b0, underrun}, 8'h00);
   endtask

   // ----------------------------------------
   // one line of test data
   // ----------------------------------------
   task automatic run_op(input int op, input logic [7:0] a, input logic [7:0] d,
                         input logic [7:0] e);
      logic [7:0] r;
      logic [7:0] v;
      logic [6:0] wa;
      logic [6:0] wr_q[$];
      case (op)
         1: begin // spi write burst returns status on miso
            spi_frame({1'b1, a[6:0]}, 3, d);
            for (int k = 1; k < 4; k++) check_val("miso_status", rx_q[k], e);
            model[a[6:0]] = d;
            flags_low();
         end
         2: begin
            spi_frame({1'b0, a[6:0]}, 3, 8'h00);
            for (int k = 1; k < 4; k++) check_val("miso_read", rx_q[k], e);
            flags_low();
         end
         3: begin
            loc_access(1'b1, a[6:0], d, r);
            model[a[6:0]] = d;
         end
         4: begin
            loc_access(1'b0, a[6:0], 8'h00, r);
            check_val("loc_dat_o", r, e);
         end
         5: begin // local writes to 0x60..0x7f during a read burst
            fork
               spi_frame({1'b0, a[6:0]}, 3, 8'h00);
               for (int i = 0; i < int'(d); i++) begin
                  rand_bits(5, v);
                  wa = 7'h60 | v[6:0];
                  rand_bits(8, v);
                  loc_access(1'b1, wa, v, r);
                  model[wa] = v;
                  wr_q.push_back(wa);
                  repeat (20) @(negedge clk);
               end
            join
            for (int k = 1; k < 4; k++) check_val("miso_read", rx_q[k], e);
            flags_low();
            foreach (wr_q[i]) begin
               loc_access(1'b0, wr_q[i], 8'h00, r);
               check_val("loc_dat_o", r, model[wr_q[i]]);
            end
         end
         6: status = d;
         7: begin // local cyc parked over a whole spi byte
            loc_cyc = 1'b1;
            repeat (2) @(negedge clk);
            fork
               spi_frame({1'b0, a[6:0]}, 2, 8'h00);
               begin
                  repeat (HALF + 2*8*2*HALF + 4) @(negedge clk);
                  loc_cyc = 1'b0;
               end
            join
            check_val("underrun_o", {7'b0, underrun}, 8'h01);
            check_val("overflow_o", {7'b0, overflow}, 8'h00);
            spi_frame({1'b0, a[6:0]}, 1, 8'h00);
            flags_low(); // cleared at the ssel fall
         end
         default: begin
            $display("unknown operation code %0d in test data", op);
            errors++;
         end
      endcase
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int         fd;
      int         cnt;
      int         op;
      int         err_before;
      logic [7:0] a, d, e;
      string      line;
      sck     = 1'b0;
      ssel    = 1'b1;
      mosi    = 1'b0;
      status  = 8'h00;
      loc_cyc = 1'b0;
      loc_stb = 1'b0;
      loc_we  = 1'b0;
      loc_adr = '0;
      loc_dat = '0;
      foreach (model[i]) model[i] = 8'h00;
      fd = $fopen("tests/spi_bridge_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open the test data file");
         $display("Test failed");
         $finish;
      end else begin
         while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
               cnt = $sscanf(line, "%h %h %h %h", op, a, d, e);
               if (cnt == 4) begin
                  op_q.push_back(op);
                  adr_q.push_back(a);
                  dat_q.push_back(d);
                  exp_q.push_back(e);
               end
            end
         end
         $fclose(fd);
         n_ops = op_q.size();
         @(negedge rst);
         @(negedge clk);
         check_val("loc_ack_o", {7'b0, loc_ack}, 8'h00);
         check_val("active_o", {7'b0, active}, 8'h00);
         check_val("miso_o", {7'b0, miso}, 8'h00);
         flags_low();
         $display("test 0 reset state: %s", (errors == 0) ? "ok" : "FAIL");
         foreach (op_q[i]) begin
            err_before = errors;
            run_op(op_q[i], adr_q[i], dat_q[i], exp_q[i]);
            $display("test %0d op %0d adr %02h: %s", i + 1, op_q[i], adr_q[i],
                     (errors == err_before) ? "ok" : "FAIL");
         end
         $display("%0d tests run, %0d errors", n_ops + 1, errors);
         if (errors == 0) begin
            $display("Test completed successfully");
         end else begin
            $display("Test failed");
         end
         $finish;
      end
   end

   // watchdog scaled by the number of operations
   initial begin
      wait (n_ops > 0);
      #(n_ops * OP_NS + MARGIN);
      $display("watchdog expired, the run took too long");
      $display("Test failed");
      $finish;
   end

endmodule

// File: tests/spi_bridge_testdata.txt
# columns: op addr data expected, all hex
# op 1 spi write, 2 spi read, 3 local write, 4 local read, 5 contention, 6 status, 7 underrun
6 00 5a 00
1 10 3c 5a
4 10 00 3c
3 22 c4 00
2 22 00 c4
6 00 81 00
1 11 7e 81
2 11 00 7e
4 11 00 7e
3 40 99 00
5 40 06 99
2 40 00 99
7 10 00 00
2 10 00 3c
1 7f ff 81
4 7f 00 ff
3 05 01 00
2 05 00 01
4 22 00 c4

// File: verilog/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // master 0 is the spi bridge
   input  logic                       m0_cyc_i,
   input  logic                       m0_stb_i,
   input  logic                       m0_we_i,
   input  logic [spi_pkg::ADDR_W-1:0] m0_adr_i,
   input  logic [spi_pkg::DATA_W-1:0] m0_dat_i,
   output logic                       m0_ack_o,
   output logic [spi_pkg::DATA_W-1:0] m0_dat_o,
   // master 1 is the local port
   input  logic                       m1_cyc_i,
   input  logic                       m1_stb_i,
   input  logic                       m1_we_i,
   input  logic [spi_pkg::ADDR_W-1:0] m1_adr_i,
   input  logic [spi_pkg::DATA_W-1:0] m1_dat_i,
   output logic                       m1_ack_o,
   output logic [spi_pkg::DATA_W-1:0] m1_dat_o,
   // shared slave
   output logic                       s_stb_o,
   output logic                       s_we_o,
   output logic [spi_pkg::ADDR_W-1:0] s_adr_o,
   output logic [spi_pkg::DATA_W-1:0] s_dat_o,
   input  logic                       s_ack_i,
   input  logic [spi_pkg::DATA_W-1:0] s_dat_i
);
   import spi_pkg::*;

   logic own_q;  // grant register
   logic last_q; // last winner
   logic hold;   // owner still has cyc up
   logic gnt;    // current grant, 1 = master 1
   logic req;    // granted master requests

   assign hold = own_q & (last_q ? m1_cyc_i : m0_cyc_i);
   assign gnt  = hold                  ? last_q  :
                 (m0_cyc_i & m1_cyc_i) ? ~last_q : // round robin on a tie
                 m1_cyc_i;
   assign req  = gnt ? m1_cyc_i : m0_cyc_i;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         own_q  <= 1'b0;
         last_q <= 1'b1; // spi side wins the first tie
      end else begin
         own_q <= req;
         if (req)
            last_q <= gnt;
      end
   end

   // request mux, no register in the path
   assign s_stb_o = req & (gnt ? m1_stb_i : m0_stb_i);
   assign s_we_o  = gnt ? m1_we_i  : m0_we_i;
   assign s_adr_o = gnt ? m1_adr_i : m0_adr_i;
   assign s_dat_o = gnt ? m1_dat_i : m0_dat_i;

   assign m0_ack_o = s_ack_i & ~gnt & m0_cyc_i;
   assign m1_ack_o = s_ack_i & gnt & m1_cyc_i;
   assign m0_dat_o = s_dat_i; // qualified by ack
   assign m1_dat_o = s_dat_i;

endmodule

// File: verilog/reg_bank.sv
`timescale 1ns/1ps

module reg_bank (
   input  logic                       clk_i,
   input  logic                       rst_i,
   input  logic                       stb_i,
   input  logic                       we_i,
   input  logic [spi_pkg::ADDR_W-1:0] adr_i,
   input  logic [spi_pkg::DATA_W-1:0] dat_i,
   output logic                       ack_o,
   output logic [spi_pkg::DATA_W-1:0] dat_o
);
   import spi_pkg::*;

   localparam int DEPTH = 2 ** ADDR_W; // 128 bytes

   logic [DATA_W-1:0] mem [DEPTH];
   logic              hit; // new strobe, not the tail of an acked one

   assign hit = stb_i & ~ack_o; // one idle cycle between acks

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else begin
         ack_o <= hit;
         if (hit && we_i)
            mem[adr_i] <= dat_i;
      end
   end

   // read data lines up with ack
   always_ff @(posedge clk_i) begin
      if (hit)
         dat_o <= mem[adr_i];
   end

endmodule

// File: verilog/spi_bridge_top.sv
`timescale 1ns/1ps

module spi_bridge_top #(
   parameter logic [spi_pkg::DATA_W-1:0] HEADER_BYTE = 8'hA7,
   parameter int                         SYNC_STAGES = 2
) (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // spi pins
   input  logic                       sck_i,
   input  logic                       ssel_i,
   input  logic                       mosi_i,
   output logic                       miso_o,
   input  logic [spi_pkg::DATA_W-1:0] status_i,
   // local port
   input  logic                       loc_cyc_i,
   input  logic                       loc_stb_i,
   input  logic                       loc_we_i,
   input  logic [spi_pkg::ADDR_W-1:0] loc_adr_i,
   input  logic [spi_pkg::DATA_W-1:0] loc_dat_i,
   output logic                       loc_ack_o,
   output logic [spi_pkg::DATA_W-1:0] loc_dat_o,
   // diagnostics
   output logic                       active_o,
   output logic                       overflow_o,
   output logic                       underrun_o
);
   import spi_pkg::*;

   // ----------------------------------------
   // layer to fsm
   // ----------------------------------------
   logic              l_cyc;
   logic              l_get;
   logic              l_rdy;
   logic              l_wat;
   logic              l_ack;
   logic [DATA_W-1:0] l_dtx; // tx byte to layer
   logic [DATA_W-1:0] l_drx; // rx byte from layer

   // spi master bus
   logic              m0_cyc;
   logic              m0_stb;
   logic              m0_we;
   logic [ADDR_W-1:0] m0_adr;
   logic [DATA_W-1:0] m0_wdat;
   logic              m0_ack;
   logic [DATA_W-1:0] m0_rdat;

   // memory bus
   logic              s_stb;
   logic              s_we;
   logic [ADDR_W-1:0] s_adr;
   logic [DATA_W-1:0] s_wdat;
   logic              s_ack;
   logic [DATA_W-1:0] s_rdat;

   assign active_o = l_cyc;

   spi_layer #(
      .HEADER_BYTE (HEADER_BYTE),
      .SYNC_STAGES (SYNC_STAGES)
   ) u_spi_layer (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .sck_i      (sck_i),
      .ssel_i     (ssel_i),
      .mosi_i     (mosi_i),
      .miso_o     (miso_o),
      .cyc_o      (l_cyc),
      .get_o      (l_get),
      .rdy_i      (l_rdy),
      .wat_o      (l_wat),
      .ack_i      (l_ack),
      .dat_i      (l_dtx),
      .dat_o      (l_drx),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   spi_slave u_spi_slave (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .l_cyc_i  (l_cyc),
      .l_get_i  (l_get),
      .l_rdy_o  (l_rdy),
      .l_wat_i  (l_wat),
      .l_ack_o  (l_ack),
      .l_dat_o  (l_dtx),
      .l_dat_i  (l_drx),
      .cyc_o    (m0_cyc),
      .stb_o    (m0_stb),
      .we_o     (m0_we),
      .adr_o    (m0_adr),
      .dat_o    (m0_wdat),
      .ack_i    (m0_ack),
      .dat_i    (m0_rdat),
      .status_i (status_i)
   );

   bus_arbiter u_bus_arbiter (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m0_cyc_i (m0_cyc),
      .m0_stb_i (m0_stb),
      .m0_we_i  (m0_we),
      .m0_adr_i (m0_adr),
      .m0_dat_i (m0_wdat),
      .m0_ack_o (m0_ack),
      .m0_dat_o (m0_rdat),
      .m1_cyc_i (loc_cyc_i),
      .m1_stb_i (loc_stb_i),
      .m1_we_i  (loc_we_i),
      .m1_adr_i (loc_adr_i),
      .m1_dat_i (loc_dat_i),
      .m1_ack_o (loc_ack_o),
      .m1_dat_o (loc_dat_o),
      .s_stb_o  (s_stb),
      .s_we_o   (s_we),
      .s_adr_o  (s_adr),
      .s_dat_o  (s_wdat),
      .s_ack_i  (s_ack),
      .s_dat_i  (s_rdat)
   );

   reg_bank u_reg_bank (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .stb_i (s_stb),
      .we_i  (s_we),
      .adr_i (s_adr),
      .dat_i (s_wdat),
      .ack_o (s_ack),
      .dat_o (s_rdat)
   );

endmodule

// File: verilog/spi_layer.sv
`timescale 1ns/1ps

module spi_layer #(
   parameter logic [spi_pkg::DATA_W-1:0] HEADER_BYTE = 8'hA7,
   parameter int                         SYNC_STAGES = 2
) (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // raw spi pins
   input  logic                       sck_i,
   input  logic                       ssel_i,
   input  logic                       mosi_i,
   output logic                       miso_o,
   // byte interface to the bridge fsm
   output logic                       cyc_o,
   output logic                       get_o,
   input  logic                       rdy_i,
   output logic                       wat_o,
   input  logic                       ack_i,
   input  logic [spi_pkg::DATA_W-1:0] dat_i,
   output logic [spi_pkg::DATA_W-1:0] dat_o,
   // diagnostics
   output logic                       overflow_o,
   output logic                       underrun_o
);
   import spi_pkg::*;

   localparam int CNT_W = $clog2(DATA_W);

   logic [SYNC_STAGES-1:0][2:0] pin_q;  // {sck, ssel, mosi} per stage
   logic                        sck_s;
   logic                        ssel_s;
   logic                        mosi_s;
   logic                        sck_q;   // last synced sck
   logic                        ssel_q;  // last synced ssel
   logic                        sck_rise;
   logic                        sck_fall;
   logic                        ssel_fall;
   logic                        byte_done;
   logic                        tx_load; // first falling edge of a new byte
   logic [CNT_W-1:0]            bit_cnt;
   logic [DATA_W-1:0]           rx_sr;
   logic [DATA_W-1:0]           tx_sr;
   logic [DATA_W-1:0]           tx_hold;
   logic                        rx_full; // received byte not yet acked
   logic                        tx_valid;

   // ----------------------------------------
   // pin synchronisers and edge detect
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pin_q  <= {SYNC_STAGES{3'b010}}; // ssel idles high
         sck_q  <= 1'b0;
         ssel_q <= 1'b1;
      end else begin
         pin_q[0] <= {sck_i, ssel_i, mosi_i};
         for (int i = 1; i < SYNC_STAGES; i++) begin
            pin_q[i] <= pin_q[i-1];
         end
         sck_q  <= sck_s;
         ssel_q <= ssel_s;
      end
   end

   assign {sck_s, ssel_s, mosi_s} = pin_q[SYNC_STAGES-1];

   assign cyc_o     = ~ssel_s;
   assign sck_rise  = cyc_o & sck_s & ~sck_q;  // mode 0 sample edge
   assign sck_fall  = cyc_o & ~sck_s & sck_q;  // mode 0 shift edge
   assign ssel_fall = ssel_q & ~ssel_s;
   assign byte_done = sck_rise && (bit_cnt == CNT_W'(DATA_W - 1));
   assign tx_load   = sck_fall && (bit_cnt == '0); // after the 8th rise
   assign wat_o     = ~rx_full;
   assign miso_o    = tx_sr[DATA_W-1];             // msb first

   // ----------------------------------------
   // receive side
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bit_cnt    <= '0;
         rx_full    <= 1'b0;
         get_o      <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         get_o <= byte_done; // ask for the next tx byte at each boundary
         if (ssel_fall)
            bit_cnt <= '0;
         else if (sck_rise)
            bit_cnt <= bit_cnt + 1'b1;
         if (ssel_fall)
            rx_full <= 1'b0;
         else if (byte_done)
            rx_full <= 1'b1;
         else if (ack_i)
            rx_full <= 1'b0;
         if (ssel_fall)
            overflow_o <= 1'b0;
         else if (byte_done && rx_full && !ack_i)
            overflow_o <= 1'b1; // previous byte never consumed
      end
   end

   always_ff @(posedge clk_i) begin
      if (sck_rise)
         rx_sr <= {rx_sr[DATA_W-2:0], mosi_s};
      if (byte_done)
         dat_o <= {rx_sr[DATA_W-2:0], mosi_s};
   end

   // ----------------------------------------
   // transmit side
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         tx_sr      <= '0;
         tx_hold    <= '0;
         tx_valid   <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         if (rdy_i)
            tx_hold <= dat_i;
         if (ssel_fall) begin
            tx_sr      <= HEADER_BYTE; // header goes out first
            tx_valid   <= 1'b0;
            underrun_o <= 1'b0;
         end else if (tx_load) begin
            tx_sr    <= rdy_i ? dat_i : tx_hold; // stale byte if late
            tx_valid <= 1'b0;
            if (!tx_valid && !rdy_i)
               underrun_o <= 1'b1;
         end else begin
            if (sck_fall)
               tx_sr <= {tx_sr[DATA_W-2:0], 1'b0};
            if (rdy_i)
               tx_valid <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/spi_pkg.sv
package spi_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int DATA_W = 8;          // spi frame and bus data width
   localparam int ADDR_W = DATA_W - 1; // command byte without the write bit

   // ----------------------------------------
   // bridge fsm
   // ----------------------------------------
   typedef enum logic [2:0] {
      ST_IDLE, // ssel high or no request yet
      ST_ADDR, // command byte waiting to be decoded
      ST_BUSY, // frame open and nothing on the bus
      ST_PUSH, // bus write in flight
      ST_PULL  // bus read in flight
   } spi_state_t;

endpackage

// File: verilog/spi_slave.sv
`timescale 1ns/1ps

module spi_slave (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // spi layer side
   input  logic                       l_cyc_i,
   input  logic                       l_get_i,
   output logic                       l_rdy_o,
   input  logic                       l_wat_i,
   output logic                       l_ack_o,
   output logic [spi_pkg::DATA_W-1:0] l_dat_o,
   input  logic [spi_pkg::DATA_W-1:0] l_dat_i,
   // classic bus master
   output logic                       cyc_o,
   output logic                       stb_o,
   output logic                       we_o,
   output logic [spi_pkg::ADDR_W-1:0] adr_o,
   output logic [spi_pkg::DATA_W-1:0] dat_o,
   input  logic                       ack_i,
   input  logic [spi_pkg::DATA_W-1:0] dat_i,
   // status byte returned in write mode
   input  logic [spi_pkg::DATA_W-1:0] status_i
);
   import spi_pkg::*;

   spi_state_t state;
   logic       we_q;      // frame mode from command bit 7
   logic       bus_q;     // classic cycle in flight
   logic       get_pend;  // tx request still unanswered
   logic       rx_new;    // byte waiting and not yet acked
   logic       cmd_we;
   logic       ans_stat;  // answer a tx request with status_i
   logic       pull_done; // bus read data back

   assign rx_new = ~l_wat_i & ~l_ack_o; // ack is seen by the layer a cycle late
   assign cmd_we = l_dat_i[DATA_W-1];

   // write command answers the first request at once
   assign ans_stat  = (state == ST_ADDR && rx_new && cmd_we) ||
                      (get_pend && we_q && (state == ST_BUSY || state == ST_PUSH));
   assign pull_done = (state == ST_PULL) && ack_i;

   assign cyc_o = bus_q;
   assign stb_o = bus_q; // classic cycle
   assign we_o  = we_q;

   // ----------------------------------------
   // bridge fsm
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || !l_cyc_i) begin // ssel high ends the frame
         state    <= ST_IDLE;
         we_q     <= 1'b0;
         bus_q    <= 1'b0;
         get_pend <= 1'b0;
         l_ack_o  <= 1'b0;
         l_rdy_o  <= 1'b0;
      end else begin
         l_ack_o <= 1'b0;
         l_rdy_o <= ans_stat | pull_done;
         if (l_get_i)
            get_pend <= 1'b1;
         if (ans_stat)
            get_pend <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (l_get_i)
                  state <= ST_ADDR; // command byte has arrived
            end
            ST_ADDR: begin
               if (rx_new) begin
                  l_ack_o  <= 1'b1;
                  we_q     <= cmd_we;
                  get_pend <= 1'b0;
                  if (cmd_we) begin
                     state <= ST_BUSY;
                  end else begin
                     bus_q <= 1'b1; // first read goes out now
                     state <= ST_PULL;
                  end
               end
            end
            ST_BUSY: begin
               if (rx_new) begin
                  l_ack_o <= 1'b1; // read mode drops mosi bytes here
                  if (we_q) begin
                     bus_q <= 1'b1;
                     state <= ST_PUSH;
                  end
               end else if (get_pend && !we_q) begin
                  get_pend <= 1'b0;
                  bus_q    <= 1'b1;
                  state    <= ST_PULL;
               end
            end
            ST_PUSH: begin
               if (ack_i) begin
                  bus_q <= 1'b0;
                  state <= ST_BUSY;
               end
            end
            ST_PULL: begin
               if (rx_new)
                  l_ack_o <= 1'b1; // ignored byte under back-pressure
               if (ack_i) begin
                  bus_q <= 1'b0;
                  state <= ST_BUSY;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ----------------------------------------
   // address, write data and tx byte
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (state == ST_ADDR && rx_new)
         adr_o <= l_dat_i[ADDR_W-1:0]; // fixed for the whole frame
      if (state == ST_BUSY && rx_new && we_q)
         dat_o <= l_dat_i;
      if (pull_done)
         l_dat_o <= dat_i;
      else if (ans_stat)
         l_dat_o <= status_i;
   end

endmodule
